// File: Bender.yml
package:
  name: ntm_forget_trainer

export_include_dirs:
  - rtl

sources:
  # Packages first, then the pipeline stages and the top level
  - files:
      - rtl/ntm_fixed_pkg.sv
      - rtl/ntm_ctrl_pkg.sv
      - rtl/ntm_sequence_ctrl.sv
      - rtl/ntm_forget_delta.sv
      - rtl/ntm_gradient_accum.sv
      - rtl/ntm_forget_trainer.sv

  # Testbench, top module ntm_forget_trainer_tb
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/ntm_forget_trainer_tb.sv

// File: rtl/ntm_ctrl_pkg.sv
////////////////////
// Sequencer state and the tag carried with each element
////////////////////

`default_nettype none

`include "ntm_trainer_macros.svh"

package ntm_ctrl_pkg;

  // Sequencer FSM
  typedef enum logic [1:0] {
    IDLE,   // Waiting for START
    ACCUM,  // Taking elements
    DRAIN   // Gradients streaming out
  } trainer_state_e;

  // Element tag, follows the data down the pipeline
  typedef struct packed {
    ntm_fixed_pkg::index_t idx;  // Element l
    logic                  first; // Belongs to step 0
    logic                  last;  // Final element of final step
  } elem_tag_t;

endpackage

`default_nettype wire

// File: rtl/ntm_fixed_pkg.sv
////////////////////
// Fixed-point datapath types and the truncating Q8 multiply
////////////////////

`default_nettype none

`include "ntm_trainer_macros.svh"

package ntm_fixed_pkg;

  // Datapath words
  typedef logic signed [`NTM_DATA_W-1:0] data_t;  // Signed Q8
  typedef logic signed [`NTM_PROD_W-1:0] prod_t;  // Untruncated product
  typedef logic signed [`NTM_ACC_W-1:0]  acc_t;   // Wrapping sums

  // Counters
  typedef logic [`NTM_IDX_W-1:0]  index_t;        // Element l within a step
  typedef logic [`NTM_STEP_W-1:0] step_t;         // Step t or step count

  // Fixed-point one
  localparam data_t FIXED_ONE = data_t'(1 << `NTM_FRAC);

  // Q8 multiply, full product then arithmetic shift and truncation
  // Used for every product in the design
  function automatic data_t q_mul(input data_t a, input data_t b);
    prod_t p;
    p = prod_t'(a) * prod_t'(b);
    return data_t'(p >>> `NTM_FRAC);
  endfunction

endpackage

`default_nettype wire

// File: rtl/ntm_forget_delta.sv
////////////////////
// Forget delta pipeline, df = ds * s(t-1) * f * (1 - f)
// Two cycles from acc_valid to df_valid, keeps last step's s and h
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_trainer_macros.svh"

module ntm_forget_delta (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  acc_valid,
  input  ntm_fixed_pkg::data_t  f,
  input  ntm_fixed_pkg::data_t  s,
  input  ntm_fixed_pkg::data_t  ds,
  input  ntm_fixed_pkg::data_t  h,
  input  ntm_fixed_pkg::index_t elem_idx,
  input  logic                  first_step,
  input  logic                  last_elem,
  output logic                  df_valid,
  output ntm_fixed_pkg::data_t  df,
  output ntm_fixed_pkg::data_t  h_prev,
  output ntm_fixed_pkg::index_t idx_out,
  output logic                  first_out,
  output logic                  last_out
);
  import ntm_fixed_pkg::*;
  import ntm_ctrl_pkg::*;

  // History of the previous step, one word per element
  data_t     s_hist [`NTM_L];
  data_t     h_hist [`NTM_L];

  data_t     s_prev;          // s(t-1;l), zero on step 0
  data_t     h_prev_rd;       // h(t-1;l), zero on step 0
  data_t     one_minus_f;
  elem_tag_t tag_in;

  // Stage A registers
  logic      valid_a;
  data_t     prod_ds;         // ds * s(t-1)
  data_t     prod_f;          // f * (1 - f)
  data_t     h_prev_a;
  elem_tag_t tag_a;

  // Stage B tag
  elem_tag_t tag_b;

  assign tag_in      = '{idx: elem_idx, first: first_step, last: last_elem};
  assign s_prev      = first_step ? '0 : s_hist[elem_idx];
  assign h_prev_rd   = first_step ? '0 : h_hist[elem_idx];
  assign one_minus_f = FIXED_ONE - f;

  ////////////////////
  // History memory
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `NTM_L; i++) begin
        s_hist[i] <= '0;
        h_hist[i] <= '0;
      end
    end else if (acc_valid) begin
      s_hist[elem_idx] <= s;              // Read above sees the old word
      h_hist[elem_idx] <= h;
    end
  end

  ////////////////////
  // Stage A
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) valid_a <= 1'b0;
    else     valid_a <= acc_valid;
  end

  always_ff @(posedge CLK) begin
    if (acc_valid) begin
      prod_ds  <= q_mul(ds, s_prev);
      prod_f   <= q_mul(f, one_minus_f);  // Sigmoid derivative
      h_prev_a <= h_prev_rd;
      tag_a    <= tag_in;
    end
  end

  ////////////////////
  // Stage B
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) df_valid <= 1'b0;
    else     df_valid <= valid_a;
  end

  always_ff @(posedge CLK) begin
    if (valid_a) begin
      df     <= q_mul(prod_ds, prod_f);   // Third truncation
      h_prev <= h_prev_a;
      tag_b  <= tag_a;
    end
  end

  assign idx_out   = tag_b.idx;
  assign first_out = tag_b.first;
  assign last_out  = tag_b.last;

endmodule

`default_nettype wire

// File: rtl/ntm_forget_trainer.sv
////////////////////
// Forget-gate trainer top, sequencer then delta pipeline then accumulators
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_forget_trainer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_fixed_pkg::step_t SIZE_T,
  input  logic                 IN_VALID,
  input  ntm_fixed_pkg::data_t F_IN,
  input  ntm_fixed_pkg::data_t S_IN,
  input  ntm_fixed_pkg::data_t DS_IN,
  input  ntm_fixed_pkg::data_t H_IN,
  output logic                 DF_VALID,
  output ntm_fixed_pkg::data_t DF_OUT,
  output logic                 OUT_VALID,
  output ntm_fixed_pkg::acc_t  B_OUT,
  output ntm_fixed_pkg::acc_t  U_OUT,
  output logic                 READY
);
  import ntm_fixed_pkg::*;

  // Sequencer to delta pipeline
  logic   acc_valid;
  data_t  seq_f;
  data_t  seq_s;
  data_t  seq_ds;
  data_t  seq_h;
  index_t seq_idx;
  logic   seq_first;
  logic   seq_last;

  // Delta pipeline to accumulators
  data_t  fd_h_prev;
  index_t fd_idx;
  logic   fd_first;
  logic   fd_last;

  logic   drain_done;           // Back to the sequencer

  ntm_sequence_ctrl u_seq (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .SIZE_T     (SIZE_T),
    .IN_VALID   (IN_VALID),
    .F_IN       (F_IN),
    .S_IN       (S_IN),
    .DS_IN      (DS_IN),
    .H_IN       (H_IN),
    .drain_done (drain_done),
    .acc_valid  (acc_valid),
    .f          (seq_f),
    .s          (seq_s),
    .ds         (seq_ds),
    .h          (seq_h),
    .elem_idx   (seq_idx),
    .first_step (seq_first),
    .last_elem  (seq_last),
    .READY      (READY)
  );

  // Delta stream leaves the chip straight from here
  ntm_forget_delta u_delta (
    .CLK        (CLK),
    .RST        (RST),
    .acc_valid  (acc_valid),
    .f          (seq_f),
    .s          (seq_s),
    .ds         (seq_ds),
    .h          (seq_h),
    .elem_idx   (seq_idx),
    .first_step (seq_first),
    .last_elem  (seq_last),
    .df_valid   (DF_VALID),
    .df         (DF_OUT),
    .h_prev     (fd_h_prev),
    .idx_out    (fd_idx),
    .first_out  (fd_first),
    .last_out   (fd_last)
  );

  ntm_gradient_accum u_accum (
    .CLK        (CLK),
    .RST        (RST),
    .df_valid   (DF_VALID),
    .df         (DF_OUT),
    .h_prev     (fd_h_prev),
    .elem_idx   (fd_idx),
    .first_step (fd_first),
    .last_elem  (fd_last),
    .OUT_VALID  (OUT_VALID),
    .B_OUT      (B_OUT),
    .U_OUT      (U_OUT),
    .drain_done (drain_done)
  );

endmodule

`default_nettype wire

// File: rtl/ntm_gradient_accum.sv
////////////////////
// Bias and recurrent gradient memories, db += df and dU += df * h(t-1)
// Streams both out over l = 0..L-1 once the last delta is in
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_trainer_macros.svh"

module ntm_gradient_accum (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  df_valid,
  input  ntm_fixed_pkg::data_t  df,
  input  ntm_fixed_pkg::data_t  h_prev,
  input  ntm_fixed_pkg::index_t elem_idx,
  input  logic                  first_step,
  input  logic                  last_elem,
  output logic                  OUT_VALID,
  output ntm_fixed_pkg::acc_t   B_OUT,
  output ntm_fixed_pkg::acc_t   U_OUT,
  output logic                  drain_done
);
  import ntm_fixed_pkg::*;

  acc_t   db_mem [`NTM_L];    // Sum of df over t
  acc_t   du_mem [`NTM_L];    // Sum of df * h(t-1) over t >= 1

  acc_t   db_term;
  acc_t   du_term;
  logic   draining;
  index_t drain_cnt;          // Element being presented

  // Sign-extended terms; h(t-1) is zero on step 0, so the dU term is too
  assign db_term = acc_t'(df);
  assign du_term = acc_t'(q_mul(df, h_prev));

  ////////////////////
  // Accumulation
  ////////////////////
  always_ff @(posedge CLK) begin
    if (df_valid) begin
      if (first_step) begin               // Step 0 starts a new sequence
        db_mem[elem_idx] <= db_term;
        du_mem[elem_idx] <= du_term;
      end else begin
        db_mem[elem_idx] <= db_mem[elem_idx] + db_term;  // Wraps
        du_mem[elem_idx] <= du_mem[elem_idx] + du_term;
      end
    end
  end

  ////////////////////
  // Drain sequence
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      draining   <= 1'b0;
      drain_cnt  <= '0;
      OUT_VALID  <= 1'b0;
      drain_done <= 1'b0;
    end else begin
      OUT_VALID  <= draining;
      drain_done <= draining && (drain_cnt == index_t'(`NTM_L - 1));
      if (df_valid && last_elem) begin    // Same edge as the final update
        draining  <= 1'b1;
        drain_cnt <= '0;
      end else if (draining) begin
        if (drain_cnt == index_t'(`NTM_L - 1)) begin
          draining <= 1'b0;
        end else begin
          drain_cnt <= drain_cnt + index_t'(1);
        end
      end
    end
  end

  // Output words, valid with OUT_VALID
  always_ff @(posedge CLK) begin
    if (draining) begin
      B_OUT <= db_mem[drain_cnt];
      U_OUT <= du_mem[drain_cnt];
    end
  end

endmodule

`default_nettype wire

// File: rtl/ntm_sequence_ctrl.sv
////////////////////
// Sequencer of the trainer, takes START and IN_VALID
// and tags each accepted element; raises READY after the drain
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_trainer_macros.svh"

module ntm_sequence_ctrl (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  ntm_fixed_pkg::step_t  SIZE_T,
  input  logic                  IN_VALID,
  input  ntm_fixed_pkg::data_t  F_IN,
  input  ntm_fixed_pkg::data_t  S_IN,
  input  ntm_fixed_pkg::data_t  DS_IN,
  input  ntm_fixed_pkg::data_t  H_IN,
  input  logic                  drain_done,
  output logic                  acc_valid,
  output ntm_fixed_pkg::data_t  f,
  output ntm_fixed_pkg::data_t  s,
  output ntm_fixed_pkg::data_t  ds,
  output ntm_fixed_pkg::data_t  h,
  output ntm_fixed_pkg::index_t elem_idx,
  output logic                  first_step,
  output logic                  last_elem,
  output logic                  READY
);
  import ntm_fixed_pkg::*;
  import ntm_ctrl_pkg::*;

  trainer_state_e state;
  step_t          t_size;     // Latched SIZE_T
  step_t          step_cnt;   // Current step t
  index_t         elem_cnt;   // Next element l
  elem_tag_t      tag;        // Tag of the registered element
  logic           accept;
  logic           final_elem;

  assign accept     = IN_VALID && (state == ACCUM);  // Strobes outside ACCUM dropped
  assign final_elem = (elem_cnt == index_t'(`NTM_L - 1)) &&
                      (step_cnt == t_size - step_t'(1));

  ////////////////////
  // FSM and counters
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      t_size    <= '0;
      step_cnt  <= '0;
      elem_cnt  <= '0;
      acc_valid <= 1'b0;
      READY     <= 1'b0;
    end else begin
      acc_valid <= accept;
      READY     <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin               // START only honoured here
            t_size   <= SIZE_T;
            step_cnt <= '0;
            elem_cnt <= '0;
            state    <= ACCUM;
          end
        end
        ACCUM: begin
          if (accept) begin
            if (final_elem) begin
              state <= DRAIN;            // Rest happens downstream
            end else if (elem_cnt == index_t'(`NTM_L - 1)) begin
              elem_cnt <= '0;            // Next step
              step_cnt <= step_cnt + step_t'(1);
            end else begin
              elem_cnt <= elem_cnt + index_t'(1);
            end
          end
        end
        DRAIN: begin
          if (drain_done) begin
            READY <= 1'b1;               // Cycle after last OUT_VALID
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Element register, loaded on acceptance
  always_ff @(posedge CLK) begin
    if (accept) begin
      f   <= F_IN;
      s   <= S_IN;
      ds  <= DS_IN;
      h   <= H_IN;
      tag <= '{idx: elem_cnt, first: (step_cnt == '0), last: final_elem};
    end
  end

  assign elem_idx   = tag.idx;
  assign first_step = tag.first;
  assign last_elem  = tag.last;

endmodule

`default_nettype wire

// File: rtl/ntm_trainer_macros.svh
////////////////////
// Compile-time sizes and fixed-point format of the forget-gate trainer
// Included by the packages and by every module that needs a size
////////////////////

`ifndef NTM_TRAINER_MACROS_SVH
`define NTM_TRAINER_MACROS_SVH

// Word widths
`define NTM_DATA_W 16                 // f, s, ds, h and df words
`define NTM_PROD_W (2*`NTM_DATA_W)    // Full-precision product
`define NTM_ACC_W  32                 // Gradient accumulators, B_OUT and U_OUT

// Fixed-point format
`define NTM_FRAC 8                    // Fraction bits, one is 256

// Vector length
`define NTM_L     8                   // Elements per step
`define NTM_IDX_W 3                   // Enough for NTM_L-1

// Sequence length
`define NTM_MAX_T  15                 // Largest SIZE_T
`define NTM_STEP_W 4                  // Enough for NTM_MAX_T

`endif

// File: sim/ntm_forget_trainer_tb.sv
////////////////////
// Self-checking testbench of the forget-gate trainer, LCG stimulus
// Reference model in the bench; run with src.f, top ntm_forget_trainer_tb
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_trainer_macros.svh"

module ntm_forget_trainer_tb;
  import ntm_fixed_pkg::*;

  localparam int NUM_RUNS   = 6;
  localparam int MAX_GAP    = 3;                                  // Idle cycles between elements
  localparam int RUN_CYCLES = `NTM_MAX_T * `NTM_L * (MAX_GAP + 1) + `NTM_L + 40;
  localparam int LIMIT      = NUM_RUNS * RUN_CYCLES + 100;        // Reset and idle slack

  logic  CLK;
  logic  RST;
  logic  START;
  step_t SIZE_T;
  logic  IN_VALID;
  data_t F_IN, S_IN, DS_IN, H_IN;
  logic  DF_VALID;
  data_t DF_OUT;
  logic  OUT_VALID;
  acc_t  B_OUT, U_OUT;
  logic  READY;

  logic        elem_legit;          // IN_VALID carries a real element
  logic [2:0]  legit_sh;            // Legit flags on their way to DF_VALID
  logic [31:0] rng_state;
  int          errors, checks, cyc, run_deltas, beats;
  logic        prev_ov, ready_seen;

  // Model state
  data_t       df_q[$];
  logic [31:0] b_q[$];
  logic [31:0] u_q[$];
  data_t       m_prev_s [`NTM_L];
  data_t       m_prev_h [`NTM_L];
  logic [31:0] m_db [`NTM_L];
  logic [31:0] m_du [`NTM_L];

  ntm_forget_trainer dut (
    .CLK(CLK), .RST(RST), .START(START), .SIZE_T(SIZE_T), .IN_VALID(IN_VALID),
    .F_IN(F_IN), .S_IN(S_IN), .DS_IN(DS_IN), .H_IN(H_IN),
    .DF_VALID(DF_VALID), .DF_OUT(DF_OUT), .OUT_VALID(OUT_VALID),
    .B_OUT(B_OUT), .U_OUT(U_OUT), .READY(READY)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;          // 100 MHz
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Q8 value in -4.0 .. +4.0
  function automatic data_t rand_q8();
    logic [31:0] r;
    r = lcg_next();
    return data_t'(int'(r[31:16] % 2049) - 1024);
  endfunction

  // Full 64-bit product, shift by the fraction, keep the low data word
  function automatic data_t trunc_mul(input data_t a, input data_t b);
    longint full;
    full = longint'(a) * longint'(b);
    full = full >>> `NTM_FRAC;
    return full[`NTM_DATA_W-1:0];
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // Model of one element, queues its df and updates the sums
  task automatic model_element(input int t, input int l, input data_t f, input data_t s,
                               input data_t ds, input data_t h);
    data_t sp, hp, df;
    logic [31:0] du_term;
    sp = (t == 0) ? data_t'(0) : m_prev_s[l];
    hp = (t == 0) ? data_t'(0) : m_prev_h[l];
    df = trunc_mul(trunc_mul(ds, sp), trunc_mul(f, data_t'((1 << `NTM_FRAC) - f)));
    du_term = 32'(signed'(trunc_mul(df, hp)));
    if (t == 0) begin
      m_db[l] = 32'(signed'(df));
      m_du[l] = du_term;
    end else begin
      m_db[l] = m_db[l] + 32'(signed'(df));   // Wraps mod 2^32
      m_du[l] = m_du[l] + du_term;
    end
    m_prev_s[l] = s;
    m_prev_h[l] = h;
    df_q.push_back(df);
  endtask

  // One full sequence of t_len steps, stray strobes included
  task automatic run_sequence(input int t_len);
    logic [31:0] r;
    data_t f, s, ds, h;
    @(posedge CLK);
    START  <= 1'b1;
    SIZE_T <= step_t'(t_len);
    @(posedge CLK);
    START  <= 1'b0;
    for (int t = 0; t < t_len; t++) begin
      for (int l = 0; l < `NTM_L; l++) begin
        r = lcg_next();
        repeat (r % (MAX_GAP + 1)) begin
          @(posedge CLK);
          IN_VALID   <= 1'b0;
          elem_legit <= 1'b0;
          START      <= (lcg_next() % 8 == 0);   // Ignored in ACCUM
        end
        f  = rand_q8();
        s  = rand_q8();
        ds = rand_q8();
        h  = rand_q8();
        @(posedge CLK);
        IN_VALID   <= 1'b1;
        elem_legit <= 1'b1;
        START      <= 1'b0;
        F_IN       <= f;
        S_IN       <= s;
        DS_IN      <= ds;
        H_IN       <= h;
        model_element(t, l, f, s, ds, h);
      end
    end
    for (int l = 0; l < `NTM_L; l++) begin
      b_q.push_back(m_db[l]);
      u_q.push_back(m_du[l]);
    end
    // Stray START and IN_VALID while draining
    @(posedge CLK);
    IN_VALID   <= 1'b1;
    elem_legit <= 1'b0;
    START      <= 1'b1;
    SIZE_T     <= step_t'(lcg_next());
    @(posedge CLK);
    IN_VALID <= 1'b0;
    START    <= 1'b0;
    while (!ready_seen) @(posedge CLK);
  endtask

  ////////////////////
  // Output monitor
  ////////////////////
  always @(negedge CLK) begin
    if (RST) begin
      compare_word("DF_VALID", DF_VALID, 0);
      compare_word("OUT_VALID", OUT_VALID, 0);
      compare_word("READY", READY, 0);
    end else begin
      // Delta stream, three edges after the drive edge
      compare_word("DF_VALID", DF_VALID, legit_sh[2]);
      if (DF_VALID) begin
        check_true(df_q.size() > 0, "DF_VALID beat arrived with no delta expected");
        if (df_q.size() > 0) compare_word("DF_OUT", DF_OUT, df_q.pop_front());
      end
      legit_sh = {legit_sh[1:0], elem_legit};
      if (DF_VALID) run_deltas++;
      // Gradient drain
      if (OUT_VALID) begin
        if (!prev_ov) beats = 0;
        check_true(b_q.size() > 0, "OUT_VALID beat arrived with no gradient expected");
        if (b_q.size() > 0) begin
          compare_word("B_OUT", B_OUT, b_q.pop_front());
          compare_word("U_OUT", U_OUT, u_q.pop_front());
        end
        beats++;
      end
      if (prev_ov && !OUT_VALID) begin
        check_true(beats == `NTM_L, "drain ended with the wrong number of beats");
        check_true(READY, "READY missing in the cycle after the last drain beat");
      end
      if (READY) begin
        check_true(prev_ov && !OUT_VALID, "READY raised outside the cycle after the drain");
        ready_seen = 1'b1;
      end
      prev_ov = OUT_VALID;
    end
  end

  // Watchdog on the cycle count
  initial begin
    cyc = 0;
    while (cyc < LIMIT) begin
      @(posedge CLK);
      cyc++;
    end
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int t_len;
    RST        = 1'b1;
    START      = 1'b0;
    SIZE_T     = '0;
    IN_VALID   = 1'b0;
    F_IN       = '0;
    S_IN       = '0;
    DS_IN      = '0;
    H_IN       = '0;
    elem_legit = 1'b0;
    legit_sh   = '0;
    rng_state  = 32'h797d_7294;
    errors     = 0;
    checks     = 0;
    run_deltas = 0;
    beats      = 0;
    prev_ov    = 1'b0;
    ready_seen = 1'b0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    repeat (2) @(posedge CLK);
    $display("test reset: done, errors so far %0d", errors);
    for (int run = 0; run < NUM_RUNS; run++) begin
      // IN_VALID while idle, must be dropped
      @(posedge CLK);
      IN_VALID <= 1'b1;
      F_IN     <= rand_q8();
      @(posedge CLK);
      IN_VALID <= 1'b0;
      if (run == 0)      t_len = 1;
      else if (run == 1) t_len = `NTM_MAX_T;
      else               t_len = 1 + int'(lcg_next() % `NTM_MAX_T);
      run_deltas = 0;
      ready_seen = 1'b0;
      run_sequence(t_len);
      repeat (2) @(posedge CLK);
      check_true(run_deltas == t_len * `NTM_L, "delta count differs from T times L");
      check_true(df_q.size() == 0, "deltas expected but never streamed out");
      check_true(b_q.size() == 0, "gradients expected but never drained");
      $display("test run %0d: T=%0d deltas=%0d, errors so far %0d",
               run, t_len, run_deltas, errors);
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/ntm_fixed_pkg.sv
rtl/ntm_ctrl_pkg.sv
rtl/ntm_sequence_ctrl.sv
rtl/ntm_forget_delta.sv
rtl/ntm_gradient_accum.sv
rtl/ntm_forget_trainer.sv
sim/ntm_forget_trainer_tb.sv
